/* verilog/cdc_pkg.sv */
package cdc_pkg;

    // Entry counts of the two crossing FIFOs
    // Both must be powers of two and at least 4
    localparam int CMD_FIFO_DEPTH = 8;
    localparam int RSP_FIFO_DEPTH = 4;

endpackage

/* verilog/msg_pkg.sv */
package msg_pkg;

    // Register bank geometry
    localparam int ADDR_W   = 4;
    localparam int DATA_W   = 32;
    localparam int NUM_REGS = 16;

    // Tag returned with every read response
    localparam int TAG_W = 4;

    typedef enum logic [0:0] {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } opcode_t;

    // Command payload, 41 bits
    typedef struct packed {
        opcode_t             op;
        logic [TAG_W-1:0]    tag;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } cmd_t;

    // Response payload, 36 bits
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [DATA_W-1:0]   rdata;
    } rsp_t;

endpackage

/* verilog/dual_port_ram.sv */
module dual_port_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic                     wclk,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    // Write port in the producer clock
    always_ff @(posedge wclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Asynchronous read gives first-word-fall-through at the FIFO
    assign rdata = mem[raddr];

endmodule

/* verilog/async_fifo.sv */
module async_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    // Write side
    input  logic     wclk,
    input  logic     wrstn,
    input  logic     winc,
    input  payload_t wdata,
    output logic     wfull,

    // Read side
    input  logic     rclk,
    input  logic     rrstn,
    input  logic     rinc,
    output payload_t rdata,
    output logic     rempty
);

    localparam int AW = $clog2(DEPTH);
    // One extra bit tells a full FIFO from an empty one
    localparam int PW = AW + 1;

    logic [PW-1:0] wbin;
    logic [PW-1:0] wgray;
    logic [PW-1:0] wbin_next;
    logic [PW-1:0] wgray_next;
    logic [PW-1:0] rbin;
    logic [PW-1:0] rgray;
    logic [PW-1:0] rbin_next;
    logic [PW-1:0] rgray_next;

    // Read pointer seen in wclk, write pointer seen in rclk
    logic [PW-1:0] rgray_q1;
    logic [PW-1:0] rgray_q2;
    logic [PW-1:0] wgray_q1;
    logic [PW-1:0] wgray_q2;

    logic wen;
    logic ren;

    assign wen = winc & ~wfull;
    assign ren = rinc & ~rempty;

    assign wbin_next  = wbin + PW'(wen);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;
    assign rbin_next  = rbin + PW'(ren);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    // Gray value is registered so the crossing bus never glitches
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wbin  <= '0;
            wgray <= '0;
        end else begin
            wbin  <= wbin_next;
            wgray <= wgray_next;
        end
    end

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rbin  <= '0;
            rgray <= '0;
        end else begin
            rbin  <= rbin_next;
            rgray <= rgray_next;
        end
    end

    // Two-flop synchronizers, reset by the receiving domain
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            rgray_q1 <= '0;
            rgray_q2 <= '0;
        end else begin
            rgray_q1 <= rgray;
            rgray_q2 <= rgray_q1;
        end
    end

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            wgray_q1 <= '0;
            wgray_q2 <= '0;
        end else begin
            wgray_q1 <= wgray;
            wgray_q2 <= wgray_q1;
        end
    end

    // Full when the writer is exactly one lap ahead of the reader
    assign wfull  = (wgray == {~rgray_q2[PW-1:PW-2], rgray_q2[PW-3:0]});
    assign rempty = (wgray_q2 == rgray);

    dual_port_ram #(
        .payload_t (payload_t),
        .DEPTH     (DEPTH)
    ) ram (
        .wclk  (wclk),
        .wen   (wen),
        .waddr (wbin[AW-1:0]),
        .wdata (wdata),
        .raddr (rbin[AW-1:0]),
        .rdata (rdata)
    );

endmodule

/* verilog/host_port.sv */
module host_port (
    input  logic                        wclk,
    input  logic                        wrstn,

    // Host command strobe
    input  logic                        cmd_valid,
    input  msg_pkg::opcode_t            cmd_op,
    input  logic [msg_pkg::TAG_W-1:0]   cmd_tag,
    input  logic [msg_pkg::ADDR_W-1:0]  cmd_addr,
    input  logic [msg_pkg::DATA_W-1:0]  cmd_wdata,
    output logic                        cmd_drop,

    // Command FIFO write side
    input  logic                        cmd_full,
    output logic                        cmd_push,
    output msg_pkg::cmd_t               cmd_payload,

    // Response FIFO read side
    input  logic                        rsp_empty,
    input  msg_pkg::rsp_t               rsp_head,
    output logic                        rsp_pop,

    // Host response strobe
    output logic                        rsp_valid,
    output logic [msg_pkg::TAG_W-1:0]   rsp_tag,
    output logic [msg_pkg::DATA_W-1:0]  rsp_rdata
);

    import msg_pkg::*;

    // No back-pressure toward the host, so a full FIFO loses the command
    assign cmd_push = cmd_valid & ~cmd_full;
    assign cmd_drop = cmd_valid & cmd_full;

    always_comb begin
        cmd_payload.op   = cmd_op;
        cmd_payload.tag  = cmd_tag;
        cmd_payload.addr = cmd_addr;
        cmd_payload.data = cmd_wdata;
    end

    // Drain one response per cycle
    assign rsp_pop = ~rsp_empty;

    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= ~rsp_empty;
        end
    end

    // Response fields only change when a new entry is taken
    always_ff @(posedge wclk) begin
        if (!rsp_empty) begin
            rsp_tag   <= rsp_head.tag;
            rsp_rdata <= rsp_head.rdata;
        end
    end

endmodule

/* verilog/reg_target.sv */
module reg_target (
    input  logic          rclk,
    input  logic          rrstn,

    // Command FIFO read side
    input  logic          cmd_empty,
    input  msg_pkg::cmd_t cmd_head,
    output logic          cmd_pop,

    // Response FIFO write side
    input  logic          rsp_full,
    output logic          rsp_push,
    output msg_pkg::rsp_t rsp_payload
);

    import msg_pkg::*;

    logic [DATA_W-1:0] bank [NUM_REGS];
    logic              is_read;
    logic              exec;

    assign is_read = (cmd_head.op == OP_READ);

    // Writes never stall, a read waits for room in the response FIFO
    assign exec     = ~cmd_empty & (~is_read | ~rsp_full);
    assign cmd_pop  = exec;
    assign rsp_push = exec & is_read;

    always_comb begin
        rsp_payload.tag   = cmd_head.tag;
        rsp_payload.rdata = bank[cmd_head.addr];
    end

    // Register bank, cleared on reset
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                bank[i] <= '0;
            end
        end else if (exec && !is_read) begin
            bank[cmd_head.addr] <= cmd_head.data;
        end
    end

endmodule

/* verilog/cdc_bridge.sv */
module cdc_bridge (
    input  logic                        wclk,
    input  logic                        wrstn,
    input  logic                        rclk,
    input  logic                        rrstn,

    // Host side, all in wclk
    input  logic                        cmd_valid,
    input  msg_pkg::opcode_t            cmd_op,
    input  logic [msg_pkg::TAG_W-1:0]   cmd_tag,
    input  logic [msg_pkg::ADDR_W-1:0]  cmd_addr,
    input  logic [msg_pkg::DATA_W-1:0]  cmd_wdata,
    output logic                        cmd_drop,
    output logic                        rsp_valid,
    output logic [msg_pkg::TAG_W-1:0]   rsp_tag,
    output logic [msg_pkg::DATA_W-1:0]  rsp_rdata
);

    import msg_pkg::*;
    import cdc_pkg::*;

    // Command path, wclk to rclk
    logic cmd_push;
    logic cmd_full;
    cmd_t cmd_payload;
    logic cmd_pop;
    logic cmd_empty;
    cmd_t cmd_head;

    // Response path, rclk to wclk
    logic rsp_push;
    logic rsp_full;
    rsp_t rsp_payload;
    logic rsp_pop;
    logic rsp_empty;
    rsp_t rsp_head;

    host_port u_host_port (
        .wclk        (wclk),
        .wrstn       (wrstn),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_tag     (cmd_tag),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_drop    (cmd_drop),
        .cmd_full    (cmd_full),
        .cmd_push    (cmd_push),
        .cmd_payload (cmd_payload),
        .rsp_empty   (rsp_empty),
        .rsp_head    (rsp_head),
        .rsp_pop     (rsp_pop),
        .rsp_valid   (rsp_valid),
        .rsp_tag     (rsp_tag),
        .rsp_rdata   (rsp_rdata)
    );

    async_fifo #(
        .payload_t (cmd_t),
        .DEPTH     (CMD_FIFO_DEPTH)
    ) cmd_fifo (
        .wclk   (wclk),
        .wrstn  (wrstn),
        .winc   (cmd_push),
        .wdata  (cmd_payload),
        .wfull  (cmd_full),
        .rclk   (rclk),
        .rrstn  (rrstn),
        .rinc   (cmd_pop),
        .rdata  (cmd_head),
        .rempty (cmd_empty)
    );

    // Write side runs on rclk, read side on wclk
    async_fifo #(
        .payload_t (rsp_t),
        .DEPTH     (RSP_FIFO_DEPTH)
    ) rsp_fifo (
        .wclk   (rclk),
        .wrstn  (rrstn),
        .winc   (rsp_push),
        .wdata  (rsp_payload),
        .wfull  (rsp_full),
        .rclk   (wclk),
        .rrstn  (wrstn),
        .rinc   (rsp_pop),
        .rdata  (rsp_head),
        .rempty (rsp_empty)
    );

    reg_target u_reg_target (
        .rclk        (rclk),
        .rrstn       (rrstn),
        .cmd_empty   (cmd_empty),
        .cmd_head    (cmd_head),
        .cmd_pop     (cmd_pop),
        .rsp_full    (rsp_full),
        .rsp_push    (rsp_push),
        .rsp_payload (rsp_payload)
    );

endmodule

/* tb/tb_cdc_bridge.sv */
module tb_cdc_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    import msg_pkg::*;

    localparam int NUM_CMDS       = 600;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * 40;

    logic              wclk;
    logic              wrstn;
    logic              rclk;
    logic              rrstn;
    logic              cmd_valid;
    opcode_t           cmd_op;
    logic [TAG_W-1:0]  cmd_tag;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic              cmd_drop;
    logic              rsp_valid;
    logic [TAG_W-1:0]  rsp_tag;
    logic [DATA_W-1:0] rsp_rdata;

    // Register model and outstanding reads in issue order
    logic [DATA_W-1:0] model [NUM_REGS];
    rsp_t              exp_q[$];
    string             name_q[$];
    string             test_name;
    logic [TAG_W-1:0]  next_tag;
    int                accepted_reads;
    int                rsp_count;
    int                drops;
    int                cycles;

    cdc_bridge UUT (
        .wclk      (wclk),
        .wrstn     (wrstn),
        .rclk      (rclk),
        .rrstn     (rrstn),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_tag   (cmd_tag),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_drop  (cmd_drop),
        .rsp_valid (rsp_valid),
        .rsp_tag   (rsp_tag),
        .rsp_rdata (rsp_rdata)
    );

    initial begin
        wclk = 1'b0;
        forever #7 wclk = ~wclk;
    end

    initial begin
        rclk = 1'b0;
        forever #10 rclk = ~rclk;
    end

    initial begin
        wrstn = 1'b0;
        repeat (10) @(posedge wclk);
        #2 wrstn = 1'b1;
    end

    initial begin
        rrstn = 1'b0;
        repeat (10) @(posedge rclk);
        #2 rrstn = 1'b1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_rsp_tag(input string name, input logic [TAG_W-1:0] expected,
                                 input logic [TAG_W-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s tag expected %0h actual %0h",
                                name, expected, actual));
        end
    endtask

    task automatic check_rsp_data(input string name, input logic [DATA_W-1:0] expected,
                                  input logic [DATA_W-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s data expected %08h actual %08h",
                                name, expected, actual));
        end
    endtask

    task automatic check_cmd_drop(input string name, input logic expected,
                                  input logic actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s cmd_drop expected %0b actual %0b",
                                name, expected, actual));
        end
    endtask

    // Drive one command, then look at cmd_drop while it is stable
    task automatic send_cmd(input opcode_t op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        rsp_t exp;
        @(posedge wclk);
        #2;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_tag   = next_tag;
        cmd_addr  = addr;
        cmd_wdata = data;
        #4;
        if (cmd_drop) begin
            drops++;
        end else if (op == OP_WRITE) begin
            model[addr] = data;
        end else begin
            exp.tag   = next_tag;
            exp.rdata = model[addr];
            exp_q.push_back(exp);
            name_q.push_back(test_name);
            accepted_reads++;
        end
        next_tag = next_tag + 1'b1;
    endtask

    // No command in the cycle, so no drop strobe either
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge wclk);
            #2;
            cmd_valid = 1'b0;
            #4;
            check_cmd_drop(test_name, 1'b0, cmd_drop);
        end
    endtask

    // Response monitor, sampled mid-cycle
    initial begin
        rsp_t  exp;
        string name;
        forever begin
            @(negedge wclk);
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("Response arrived with no outstanding read");
                end else begin
                    exp  = exp_q.pop_front();
                    name = name_q.pop_front();
                    check_rsp_tag(name, exp.tag, rsp_tag);
                    check_rsp_data(name, exp.rdata, rsp_rdata);
                    rsp_count++;
                end
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge wclk);
            cycles++;
        end
        abort_run("Timeout: responses did not drain in time");
    end

    initial begin
        cmd_valid      = 1'b0;
        cmd_op         = OP_WRITE;
        cmd_tag        = '0;
        cmd_addr       = '0;
        cmd_wdata      = '0;
        next_tag       = '0;
        accepted_reads = 0;
        rsp_count      = 0;
        drops          = 0;
        cycles         = 0;
        test_name      = "startup";
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        void'($urandom(9788));

        wait (wrstn && rrstn);
        idle_cycles(5);

        // Every register reads zero after reset
        test_name = "reset_reads";
        for (int i = 0; i < NUM_REGS; i++) begin
            send_cmd(OP_READ, ADDR_W'(i), '0);
            idle_cycles(3);
        end

        // Mixed traffic with random gaps
        test_name = "random_mix";
        for (int i = 0; i < 400; i++) begin
            idle_cycles($urandom_range(0, 3));
            send_cmd(($urandom_range(0, 1) == 1) ? OP_READ : OP_WRITE,
                     ADDR_W'($urandom), DATA_W'($urandom));
        end
        idle_cycles(20);

        // Back-to-back writes overrun the FIFO, reads then expose any dropped write
        test_name = "drop_bursts";
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 12; i++) begin
                send_cmd(OP_WRITE, ADDR_W'($urandom), DATA_W'($urandom));
            end
            for (int i = 0; i < NUM_REGS; i++) begin
                send_cmd(OP_READ, ADDR_W'(i), '0);
            end
            idle_cycles(30);
        end

        test_name = "read_burst";
        for (int i = 0; i < 72; i++) begin
            send_cmd(OP_READ, ADDR_W'($urandom), '0);
        end
        idle_cycles(1);

        // Every accepted read must come back once
        while (rsp_count != accepted_reads) begin
            @(posedge wclk);
        end
        // Quiet tail to catch stray responses
        idle_cycles(60);

        if (drops == 0) begin
            abort_run("No command was dropped, the command FIFO never filled");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* verilog.f */
verilog/cdc_pkg.sv
verilog/msg_pkg.sv
verilog/dual_port_ram.sv
verilog/async_fifo.sv
verilog/host_port.sv
verilog/reg_target.sv
verilog/cdc_bridge.sv
tb/tb_cdc_bridge.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_cdc_bridge -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
else
    exit 1
fi
